// File: common/mdu_op_pkg.sv
// ALU operation codes seen by the multiply and HI/LO block
// signed / unsigned classification of the multiply operations
`default_nettype none

package mdu_op_pkg;

    localparam int ALUOP_W = 6;

    typedef enum logic [ALUOP_W-1:0] {
        ALU_NOP   = 6'h00,
        ALU_MFHI  = 6'h10,
        ALU_MTHI  = 6'h11,
        ALU_MFLO  = 6'h12,
        ALU_MTLO  = 6'h13,
        ALU_MULT  = 6'h18,
        ALU_MULTU = 6'h19,
        ALU_MUL   = 6'h1c,
        ALU_MADD  = 6'h20,
        ALU_MADDU = 6'h21,
        ALU_MSUB  = 6'h24,
        ALU_MSUBU = 6'h25
    } aluop_e;

    // operations whose operands are two's complement
    function automatic logic is_signed_mult(aluop_e op);
        logic res;
        case (op)
            ALU_MULT,
            ALU_MUL,
            ALU_MADD,
            ALU_MSUB: res = 1'b1;
            default:  res = 1'b0;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

// File: common/mdu_data_pkg.sv
// data widths of the multiply path
// HI/LO pair as doubleword or as hi/lo words
// partial product pair layout
`default_nettype none

package mdu_data_pkg;

    localparam int HALF_W  = 16;
    localparam int WORD_W  = 32;
    localparam int DWORD_W = 64;

    typedef struct packed {
        logic [WORD_W-1:0] hi;
        logic [WORD_W-1:0] lo;
    } hilo_words_t;

    // MTHI/MTLO work on the halves, the multiply ops on the whole pair
    typedef union packed {
        logic [DWORD_W-1:0] dword;
        hilo_words_t        half;
    } hilo_u;

    // upper is the term weighted by 2^16 relative to lower
    typedef struct packed {
        logic [WORD_W-1:0] upper;
        logic [WORD_W-1:0] lower;
    } pprod_t;

endpackage

`default_nettype wire

// File: mdu/mdu_operand_stage.sv
// operand stage of the multiply unit
// absolute value and product sign for signed ops,
// four 16x16 partial products and the stage register
`timescale 1ns/1ps
`default_nettype none

module mdu_operand_stage (
    input  wire                                   clk,
    input  wire                                   arst_n_i,
    input  wire                                   valid_i,
    input  mdu_op_pkg::aluop_e                    aluop_i,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       opa_i,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       opb_i,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       alures_i,

    output logic                                  valid_o,
    output mdu_op_pkg::aluop_e                    aluop_o,
    output logic [mdu_data_pkg::WORD_W-1:0]       alures_o,
    output mdu_data_pkg::pprod_t                  mulhi_o,
    output mdu_data_pkg::pprod_t                  mullo_o,
    output logic                                  mul_s_o
);

    import mdu_op_pkg::*;
    import mdu_data_pkg::*;

    logic              sgn_op;
    logic              mul_s;
    logic [WORD_W-1:0] a_mag;
    logic [WORD_W-1:0] b_mag;
    logic [HALF_W-1:0] a_hi;
    logic [HALF_W-1:0] a_lo;
    logic [HALF_W-1:0] b_hi;
    logic [HALF_W-1:0] b_lo;
    pprod_t            mulhi;
    pprod_t            mullo;

    assign sgn_op = is_signed_mult(aluop_i);

    // 0x80000000 stays 0x80000000, which is the right unsigned magnitude
    assign a_mag = (sgn_op && opa_i[WORD_W-1]) ? -opa_i : opa_i;
    assign b_mag = (sgn_op && opb_i[WORD_W-1]) ? -opb_i : opb_i;
    assign mul_s = sgn_op & (opa_i[WORD_W-1] ^ opb_i[WORD_W-1]);

    assign a_hi = a_mag[WORD_W-1:HALF_W];
    assign a_lo = a_mag[HALF_W-1:0];
    assign b_hi = b_mag[WORD_W-1:HALF_W];
    assign b_lo = b_mag[HALF_W-1:0];

    always_comb begin
        mullo.lower = WORD_W'(a_lo) * WORD_W'(b_lo);
        mullo.upper = WORD_W'(a_hi) * WORD_W'(b_lo);
        mulhi.lower = WORD_W'(a_lo) * WORD_W'(b_hi);
        mulhi.upper = WORD_W'(a_hi) * WORD_W'(b_hi);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            aluop_o <= ALU_NOP;
        end else begin
            valid_o <= valid_i;
            aluop_o <= valid_i ? aluop_i : ALU_NOP; // bubble when idle
        end
    end

    always_ff @(posedge clk) begin
        alures_o <= alures_i;
        mulhi_o  <= mulhi;
        mullo_o  <= mullo;
        mul_s_o  <= mul_s;
    end

endmodule

`default_nettype wire

// File: mdu/mdu_result.sv
// result stage of the multiply unit
// product assembly from partial products and sign application
// per-operation HI/LO update and result selection
`timescale 1ns/1ps
`default_nettype none

module mdu_result (
    input  wire                                   valid_i,
    input  mdu_op_pkg::aluop_e                    aluop_i,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       alures_i,
    input  mdu_data_pkg::pprod_t                  mulhi_i,
    input  mdu_data_pkg::pprod_t                  mullo_i,
    input  wire                                   mul_s_i,
    input  mdu_data_pkg::hilo_u                   hilo_i,

    output logic                                  valid_o,
    output logic [mdu_data_pkg::WORD_W-1:0]       alures_o,
    output logic                                  whilo_o,
    output mdu_data_pkg::hilo_u                   hilo_o
);

    import mdu_op_pkg::*;
    import mdu_data_pkg::*;

    localparam int PART_W = WORD_W + HALF_W; // width of each half-product

    logic [PART_W-1:0]  reslo;
    logic [PART_W-1:0]  reshi;
    logic [DWORD_W-1:0] umres;
    logic [DWORD_W-1:0] smres;
    logic               hilo_wr;

    // b_lo * a and b_hi * a, neither can overflow 48 bits
    assign reslo = {{HALF_W{1'b0}}, mullo_i.lower} + {mullo_i.upper, {HALF_W{1'b0}}};
    assign reshi = {{HALF_W{1'b0}}, mulhi_i.lower} + {mulhi_i.upper, {HALF_W{1'b0}}};
    assign umres = {{HALF_W{1'b0}}, reslo} + {reshi, {HALF_W{1'b0}}};
    assign smres = mul_s_i ? -umres : umres;

    assign valid_o = valid_i;
    assign whilo_o = valid_i & hilo_wr;

    always_comb begin
        hilo_wr  = 1'b1;
        hilo_o   = hilo_i;
        alures_o = '0;
        case (aluop_i)
            ALU_MTHI: begin
                hilo_o.half.hi = alures_i;
            end

            ALU_MTLO: begin
                hilo_o.half.lo = alures_i;
            end

            ALU_MULT: begin
                hilo_o.dword = smres;
            end

            ALU_MULTU: begin
                hilo_o.dword = umres;
            end

            ALU_MADD: begin
                hilo_o.dword = hilo_i.dword + smres;
            end

            ALU_MADDU: begin
                hilo_o.dword = hilo_i.dword + umres;
            end

            ALU_MSUB: begin
                hilo_o.dword = hilo_i.dword - smres;
            end

            ALU_MSUBU: begin
                hilo_o.dword = hilo_i.dword - umres;
            end

            ALU_MUL: begin
                hilo_wr  = 1'b0;
                alures_o = smres[WORD_W-1:0]; // low word only, HI/LO untouched
            end

            ALU_MFHI: begin
                hilo_wr  = 1'b0;
                alures_o = hilo_i.half.hi;
            end

            ALU_MFLO: begin
                hilo_wr  = 1'b0;
                alures_o = hilo_i.half.lo;
            end

            default: begin
                hilo_wr  = 1'b0;
                alures_o = alures_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mdu/mdu_hilo.sv
// architectural HI/LO register
// write enable with flush cancel, async reset to a set value
`timescale 1ns/1ps
`default_nettype none

module mdu_hilo #(
    parameter logic [mdu_data_pkg::DWORD_W-1:0] HILO_RST = '0
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   we_i,
    input  wire                   flush_i,
    input  mdu_data_pkg::hilo_u   hilo_i,

    output mdu_data_pkg::hilo_u   hilo_o
);

    import mdu_data_pkg::*;

    hilo_u hilo_q;
    logic  wr_en;

    assign wr_en = we_i & ~flush_i; // flush drops the write of the result-stage op

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hilo_q.dword <= HILO_RST;
        end else if (wr_en) begin
            hilo_q <= hilo_i;
        end
    end

    assign hilo_o = hilo_q;

endmodule

`default_nettype wire

// File: verilog/mdu_top.sv
// top level of the multiply and HI/LO block
// operand stage, result stage and HI/LO register
`timescale 1ns/1ps
`default_nettype none

module mdu_top #(
    parameter logic [mdu_data_pkg::DWORD_W-1:0] HILO_RST = '0
) (
    input  wire                                   clk,
    input  wire                                   arst_n_i,
    input  wire                                   valid_i,
    input  mdu_op_pkg::aluop_e                    aluop_i,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       opa_i,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       opb_i,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       alures_i,
    input  wire                                   flush_i,

    output logic                                  valid_o,
    output logic [mdu_data_pkg::WORD_W-1:0]       alures_o,
    output mdu_data_pkg::hilo_u                   hilo_o
);

    import mdu_op_pkg::*;
    import mdu_data_pkg::*;

    logic              s1_valid;
    aluop_e            s1_aluop;
    logic [WORD_W-1:0] s1_alures;
    pprod_t            s1_mulhi;
    pprod_t            s1_mullo;
    logic              s1_mul_s;
    logic              whilo;
    hilo_u             hilo_next;
    hilo_u             hilo_q;

    mdu_operand_stage u_operand_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .aluop_i  (aluop_i),
        .opa_i    (opa_i),
        .opb_i    (opb_i),
        .alures_i (alures_i),
        .valid_o  (s1_valid),
        .aluop_o  (s1_aluop),
        .alures_o (s1_alures),
        .mulhi_o  (s1_mulhi),
        .mullo_o  (s1_mullo),
        .mul_s_o  (s1_mul_s)
    );

    mdu_result u_result (
        .valid_i  (s1_valid),
        .aluop_i  (s1_aluop),
        .alures_i (s1_alures),
        .mulhi_i  (s1_mulhi),
        .mullo_i  (s1_mullo),
        .mul_s_i  (s1_mul_s),
        .hilo_i   (hilo_q),
        .valid_o  (valid_o),
        .alures_o (alures_o),
        .whilo_o  (whilo),
        .hilo_o   (hilo_next)
    );

    mdu_hilo #(
        .HILO_RST (HILO_RST)
    ) u_hilo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (whilo),
        .flush_i  (flush_i),
        .hilo_i   (hilo_next),
        .hilo_o   (hilo_q)
    );

    assign hilo_o = hilo_q; // committed value, also read back by the result stage

endmodule

`default_nettype wire

// File: testbench/mdu_asserts.sv
// concurrent checks on the multiply and HI/LO block
// bound into mdu_top
`timescale 1ns/1ps
`default_nettype none

module mdu_asserts (
    input  wire                                   clk,
    input  wire                                   arst_n_i,
    input  wire                                   flush_i,
    input  wire                                   valid_o,
    input  wire                                   s1_valid,
    input  mdu_op_pkg::aluop_e                    s1_aluop,
    input  wire  [mdu_data_pkg::WORD_W-1:0]       alures_o,
    input  mdu_data_pkg::hilo_u                   hilo_o
);

    import mdu_op_pkg::*;

    int   fail_cnt = 0; // read by the testbench summary
    logic wr_op;

    always_comb begin
        case (s1_aluop)
            ALU_MTHI, ALU_MTLO, ALU_MULT, ALU_MULTU,
            ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU: wr_op = 1'b1;
            default:                                  wr_op = 1'b0;
        endcase
    end

    valid_in_reset: assert property (@(posedge clk) !arst_n_i |-> !valid_o)
        else begin
            fail_cnt++;
            $error("valid_o high while reset is asserted");
        end

    flush_holds_hilo: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> $stable(hilo_o.dword))
        else begin
            fail_cnt++;
            $error("hilo_o changed in a flushed cycle");
        end

    wr_op_zero_res: assert property (@(posedge clk) disable iff (!arst_n_i)
        (s1_valid && wr_op) |-> (alures_o == '0))
        else begin
            fail_cnt++;
            $error("alures_o not zero for a HI/LO write");
        end

endmodule

bind mdu_top mdu_asserts u_asserts (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .valid_o  (valid_o),
    .s1_valid (s1_valid),
    .s1_aluop (s1_aluop),
    .alures_o (alures_o),
    .hilo_o   (hilo_o)
);

`default_nettype wire

// File: testbench/tb_mdu.sv
// testbench for the multiply and HI/LO block
// cycle model of the two stages, directed tests, compare tasks, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mdu;

    import mdu_op_pkg::*;
    import mdu_data_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 10;
    localparam int N_CORNER   = 4;
    localparam int N_RAND     = 16;
    localparam int N_ACCUM    = 24;
    localparam int N_PASS     = 6;
    localparam int DRAIN      = 2;
    localparam int TEST_CYCLES = RST_CYCLES + 1 + (6 + DRAIN)
                               + (3 * N_CORNER * N_CORNER + 3 * N_RAND + DRAIN)
                               + (4 + N_ACCUM + DRAIN) + (N_PASS + DRAIN) + (7 + DRAIN) + DRAIN;
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;
    localparam logic [DWORD_W-1:0] HILO_RST = 64'h0123_4567_89ab_cdef;

    logic              clk;
    logic              arst_n_i;
    logic              valid_i;
    aluop_e            aluop_i;
    logic [WORD_W-1:0] opa_i;
    logic [WORD_W-1:0] opb_i;
    logic [WORD_W-1:0] alures_i;
    logic              flush_i;
    logic              valid_o;
    logic [WORD_W-1:0] alures_o;
    hilo_u             hilo_o;

    integer            seed;
    int                err_cnt;
    int                chk_cnt;
    int                cyc_cnt;
    logic              pend_flush;  // flush for the op now entering the result stage
    // model of the result-stage instruction and the committed HI/LO
    logic              m_valid;
    aluop_e            m_op;
    logic [WORD_W-1:0] m_a;
    logic [WORD_W-1:0] m_b;
    logic [WORD_W-1:0] m_alu;
    hilo_u             m_hilo;

    mdu_top #(
        .HILO_RST (HILO_RST)
    ) dut0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .aluop_i  (aluop_i),
        .opa_i    (opa_i),
        .opb_i    (opb_i),
        .alures_i (alures_i),
        .flush_i  (flush_i),
        .valid_o  (valid_o),
        .alures_o (alures_o),
        .hilo_o   (hilo_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d clock cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [WORD_W-1:0] rand_word();
        return $random(seed);
    endfunction

    task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                              input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_hilo(input hilo_u got, input hilo_u exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s is 0x%08h_%08h, expected 0x%08h_%08h", $time, what,
                     got.half.hi, got.half.lo, exp.half.hi, exp.half.lo);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // expected result of one operation from 64-bit reference arithmetic
    task automatic model_op(input aluop_e op, input logic [WORD_W-1:0] a,
                            input logic [WORD_W-1:0] b, input logic [WORD_W-1:0] alu,
                            input hilo_u hilo, output logic [WORD_W-1:0] res,
                            output logic wr, output hilo_u nxt);
        logic signed [DWORD_W-1:0] sprod;
        logic [DWORD_W-1:0]        uprod;
        sprod = $signed({{WORD_W{a[WORD_W-1]}}, a}) * $signed({{WORD_W{b[WORD_W-1]}}, b});
        uprod = {{WORD_W{1'b0}}, a} * {{WORD_W{1'b0}}, b};
        nxt   = hilo;
        wr    = 1'b1;
        res   = '0;
        case (op)
            ALU_MTHI:  nxt.half.hi = alu;
            ALU_MTLO:  nxt.half.lo = alu;
            ALU_MULT:  nxt.dword = sprod;
            ALU_MULTU: nxt.dword = uprod;
            ALU_MADD:  nxt.dword = hilo.dword + sprod;
            ALU_MADDU: nxt.dword = hilo.dword + uprod;
            ALU_MSUB:  nxt.dword = hilo.dword - sprod;
            ALU_MSUBU: nxt.dword = hilo.dword - uprod;
            ALU_MUL: begin
                wr  = 1'b0;
                res = sprod[WORD_W-1:0];
            end
            ALU_MFHI: begin
                wr  = 1'b0;
                res = hilo.half.hi;
            end
            ALU_MFLO: begin
                wr  = 1'b0;
                res = hilo.half.lo;
            end
            default: begin
                wr  = 1'b0;
                res = alu;
            end
        endcase
    endtask

    // one clock: commit the model, drive the next op, check at the falling edge
    task automatic run_cycle(input logic v, input aluop_e op, input logic [WORD_W-1:0] a,
                             input logic [WORD_W-1:0] b, input logic [WORD_W-1:0] alu,
                             input logic fl);
        logic [WORD_W-1:0] res;
        logic              wr;
        hilo_u             nxt;
        @(posedge clk);
        model_op(m_op, m_a, m_b, m_alu, m_hilo, res, wr, nxt);
        if (m_valid && wr && !flush_i) begin
            m_hilo = nxt;
        end
        m_valid = valid_i;
        m_op    = valid_i ? aluop_i : ALU_NOP;
        m_a     = opa_i;
        m_b     = opb_i;
        m_alu   = alures_i;
        valid_i  <= v;
        aluop_i  <= op;
        opa_i    <= a;
        opb_i    <= b;
        alures_i <= alu;
        flush_i  <= pend_flush;
        pend_flush = fl;
        @(negedge clk);
        model_op(m_op, m_a, m_b, m_alu, m_hilo, res, wr, nxt);
        check_flag(valid_o, m_valid, "valid_o");
        if (m_valid) begin
            check_word(alures_o, res, "alures_o");
        end
        check_hilo(hilo_o, m_hilo, "hilo_o");
    endtask

    task automatic issue(input aluop_e op, input logic [WORD_W-1:0] a,
                         input logic [WORD_W-1:0] b, input logic [WORD_W-1:0] alu,
                         input logic fl);
        run_cycle(1'b1, op, a, b, alu, fl);
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle(1'b0, ALU_NOP, '0, '0, '0, 1'b0);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_flag(valid_o, 1'b0, "valid_o after reset");
        check_hilo(hilo_o, HILO_RST, "hilo_o after reset");
    endtask

    task automatic test_hilo_moves();
        issue(ALU_MTHI, rand_word(), rand_word(), 32'hcafe_f00d, 1'b0);
        issue(ALU_MFHI, '0, '0, rand_word(), 1'b0); // reads HI right after MTHI wrote it
        issue(ALU_MTLO, rand_word(), rand_word(), 32'h1357_9bdf, 1'b0);
        issue(ALU_MFLO, '0, '0, rand_word(), 1'b0); // reads LO right after MTLO wrote it
        issue(ALU_MFHI, '0, '0, rand_word(), 1'b0);
        issue(ALU_MFLO, '0, '0, rand_word(), 1'b0);
        idle(DRAIN);
    endtask

    task automatic test_multiply();
        logic [WORD_W-1:0] corner [0:N_CORNER-1];
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        corner[0] = 32'h0000_0000;
        corner[1] = 32'h8000_0000;
        corner[2] = 32'hffff_ffff;
        corner[3] = 32'h7fff_ffff;
        for (int i = 0; i < N_CORNER; i++) begin
            for (int j = 0; j < N_CORNER; j++) begin
                issue(ALU_MULT, corner[i], corner[j], rand_word(), 1'b0);
                issue(ALU_MULTU, corner[i], corner[j], rand_word(), 1'b0);
                issue(ALU_MUL, corner[i], corner[j], rand_word(), 1'b0);
            end
        end
        for (int k = 0; k < N_RAND; k++) begin
            a = rand_word();
            b = rand_word();
            issue(ALU_MULT, a, b, rand_word(), 1'b0);
            issue(ALU_MULTU, a, b, rand_word(), 1'b0);
            issue(ALU_MUL, b, a, rand_word(), 1'b0);
        end
        idle(DRAIN);
    endtask

    task automatic test_accumulate();
        logic [WORD_W-1:0] r;
        aluop_e            op;
        issue(ALU_MTHI, '0, '0, rand_word(), 1'b0);
        issue(ALU_MTLO, '0, '0, rand_word(), 1'b0);
        for (int k = 0; k < N_ACCUM; k++) begin
            r = rand_word();
            case (r[1:0])
                2'd0:    op = ALU_MADD;
                2'd1:    op = ALU_MADDU;
                2'd2:    op = ALU_MSUB;
                default: op = ALU_MSUBU;
            endcase
            issue(op, rand_word(), rand_word(), rand_word(), 1'b0);
        end
        issue(ALU_MFHI, '0, '0, '0, 1'b0);
        issue(ALU_MFLO, '0, '0, '0, 1'b0);
        idle(DRAIN);
    endtask

    task automatic test_pass_through();
        logic [5:0] codes [0:N_PASS-1];
        codes[0] = 6'h00;
        codes[1] = 6'h01;
        codes[2] = 6'h14;
        codes[3] = 6'h1a;
        codes[4] = 6'h2a;
        codes[5] = 6'h3f;
        for (int k = 0; k < N_PASS; k++) begin
            issue(aluop_e'(codes[k]), rand_word(), rand_word(), rand_word(), 1'b0);
        end
        idle(DRAIN);
    endtask

    task automatic test_flush();
        issue(ALU_MTHI, '0, '0, 32'hdead_beef, 1'b1);
        issue(ALU_MFHI, '0, '0, '0, 1'b0);
        issue(ALU_MULT, rand_word(), rand_word(), '0, 1'b1);
        issue(ALU_MADD, rand_word(), rand_word(), '0, 1'b0);
        issue(ALU_MSUB, rand_word(), rand_word(), '0, 1'b1); // dropped right after a write
        issue(ALU_MFLO, '0, '0, '0, 1'b0);
        issue(ALU_MFHI, '0, '0, '0, 1'b0);
        idle(DRAIN);
    endtask

    initial begin
        int asrt_cnt;
        seed       = 32'h173b_edab;
        err_cnt    = 0;
        chk_cnt    = 0;
        cyc_cnt    = 0;
        pend_flush = 1'b0;
        m_valid    = 1'b0;
        m_op       = ALU_NOP;
        m_a        = '0;
        m_b        = '0;
        m_alu      = '0;
        m_hilo     = HILO_RST;
        arst_n_i   = 1'b1;
        valid_i    = 1'b0;
        aluop_i    = ALU_NOP;
        opa_i      = '0;
        opb_i      = '0;
        alures_i   = '0;
        flush_i    = 1'b0;
        #(CLK_PERIOD / 4);
        arst_n_i = 1'b0; // real falling edge for the async reset
        repeat (RST_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;

        test_reset();
        test_hilo_moves();
        test_multiply();
        test_accumulate();
        test_pass_through();
        test_flush();
        idle(DRAIN);

        asrt_cnt = dut0.u_asserts.fail_cnt;
        $display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, asrt_cnt);
        if (err_cnt == 0 && asrt_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
common/mdu_op_pkg.sv
common/mdu_data_pkg.sv
mdu/mdu_operand_stage.sv
mdu/mdu_result.sv
mdu/mdu_hilo.sv
verilog/mdu_top.sv
testbench/mdu_asserts.sv
testbench/tb_mdu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_mdu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
